// ==== Makefile ====
TOP := tb_dtlb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
		-f filelist.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF "*** TEST PASSED ***" $(LOG) || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== common/dtlb_pkg.sv ====
`default_nettype none

// Shared types for the data TLB
package dtlb_pkg;

   // Virtual page number, address bits 31 to 12
   typedef logic [19:0] vpn_t;

   // Physical page number from the page table
   typedef logic [19:0] ppn_t;

   // Page flags as stored in a page directory or page table entry
   typedef logic [3:0] page_flags_t;

   // Flag bit positions within page_flags_t
   localparam int FLAG_PRESENT   = 0;
   localparam int FLAG_WRITEABLE = 1;
   localparam int FLAG_KERNEL    = 2;
   localparam int FLAG_GLOBAL    = 3;

   // Translation as held in the TLB and returned to the client
   typedef struct packed {
      ppn_t        ppn;
      page_flags_t flags;
   } tlb_resp_t;

   // Walker answer, with both flag levels still separate
   typedef struct packed {
      ppn_t        ppn;
      page_flags_t pagedir_flags;
      page_flags_t pagetab_flags;
   } walk_result_t;

   // Lookup controller states
   typedef enum logic [1:0] {
      // Waiting for a request
      ST_IDLE      = 2'd0,
      // Arrays were read last cycle, tag compare result is ready
      ST_COMPARING = 2'd1,
      // Miss, waiting for the page table walker
      ST_WALKING   = 2'd2
   } lookup_state_e;

endpackage

`default_nettype wire

// ==== dtlb/dtlb_entry_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module dtlb_entry_store
   import dtlb_pkg::*;
#(
   parameter int SET_BITS = 4
) (
   input  wire logic      clkrst_mem_clk,
   input  wire logic      clkrst_mem_rst_n,

   // Read and compare
   input  wire vpn_t      read_vpn,
   output logic [1:0]     hit_way,

   // Recently used update for a hit
   input  wire logic      touch_en,
   input  wire logic      touch_way,

   // Fill from a walk
   input  wire logic      fill_en,
   input  wire vpn_t      fill_vpn,
   input  wire tlb_resp_t fill_data,
   output logic           victim_way,

   // Response path
   input  wire logic      resp_way,
   output tlb_resp_t      resp
);

   localparam int TAG_BITS = 20 - SET_BITS;
   localparam int NUM_SETS = 1 << SET_BITS;
   // Fixed at two, the one-bit replacement state depends on it
   localparam int WAYS     = 2;

   // Per set and way storage
   logic [NUM_SETS-1:0][WAYS-1:0] valid_q;
   logic [TAG_BITS-1:0]           tag_q [NUM_SETS][WAYS];
   tlb_resp_t                     data_q [NUM_SETS][WAYS];

   // One bit per set, names the way to evict next
   logic [NUM_SETS-1:0]           repl_q;

   // Split of the read and fill page numbers
   logic [SET_BITS-1:0]           read_set;
   logic [TAG_BITS-1:0]           read_tag;
   logic [SET_BITS-1:0]           fill_set;
   logic [TAG_BITS-1:0]           fill_tag;

   // Set read last cycle, the one hit_way refers to
   logic [SET_BITS-1:0]           read_set_q;

   logic [WAYS-1:0]               hit_comb;
   logic [WAYS-1:0]               fill_we;
   tlb_resp_t                     rd_data_q [WAYS];

   // Tag is the upper part of the vpn, set index the lower part
   assign read_set = read_vpn[SET_BITS-1:0];
   assign read_tag = read_vpn[19:SET_BITS];
   assign fill_set = fill_vpn[SET_BITS-1:0];
   assign fill_tag = fill_vpn[19:SET_BITS];

   // Victim comes straight from the replacement bit of the fill set
   assign victim_way = repl_q[fill_set];
   assign fill_we    = fill_en ? (victim_way ? 2'b10 : 2'b01) : 2'b00;

   // Tag compare on both ways of the set being read
   always_comb begin
      for (int w = 0; w < WAYS; w++) begin
         hit_comb[w] = valid_q[read_set][w] && (tag_q[read_set][w] == read_tag);
      end
   end

   // Control state: valid bits, replacement bits, registered compare
   always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         valid_q    <= '0;
         repl_q     <= '0;
         hit_way    <= '0;
         read_set_q <= '0;
      end else begin
         hit_way    <= hit_comb;
         read_set_q <= read_set;

         if (fill_en) begin
            valid_q[fill_set][victim_way] <= 1'b1;
            // Filled way becomes most recent
            repl_q[fill_set] <= ~repl_q[fill_set];
         end else if (touch_en) begin
            // Point at the way that was not hit
            repl_q[read_set_q] <= ~touch_way;
         end
      end
   end

   // Tag and translation arrays
   always_ff @(posedge clkrst_mem_clk) begin
      for (int w = 0; w < WAYS; w++) begin
         if (fill_we[w]) begin
            tag_q[fill_set][w]  <= fill_tag;
            data_q[fill_set][w] <= fill_data;
         end
      end
   end

   // Registered read of both ways
   // Write-first, so the cycle after a fill already sees the new entry
   always_ff @(posedge clkrst_mem_clk) begin
      for (int w = 0; w < WAYS; w++) begin
         if (fill_we[w] && (fill_set == read_set)) begin
            rd_data_q[w] <= fill_data;
         end else begin
            rd_data_q[w] <= data_q[read_set][w];
         end
      end
   end

   assign resp = rd_data_q[resp_way];

endmodule

`default_nettype wire

// ==== dtlb/dtlb_lookup_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dtlb_lookup_ctrl
   import dtlb_pkg::*;
#(
   parameter int SET_BITS = 4
) (
   input  wire logic         clkrst_mem_clk,
   input  wire logic         clkrst_mem_rst_n,

   // Client side
   input  wire logic         dtlb_re,
   input  wire vpn_t         dtlb_vpn,
   output logic             dtlb_ready,

   // Walker side
   output logic             ptw_re,
   output vpn_t             ptw_vpn,
   input  wire logic         ptw_ready,
   input  wire walk_result_t ptw_result,

   // Entry store side
   output vpn_t             read_vpn,
   input  wire logic [1:0]   hit_way,
   output logic             touch_en,
   output logic             touch_way,
   output logic             fill_en,
   output vpn_t             fill_vpn,
   output tlb_resp_t        fill_data,
   input  wire logic         victim_way,
   output logic             resp_way
);

   localparam int TAG_BITS = 20 - SET_BITS;

   lookup_state_e state_q;
   lookup_state_e next_state;

   // Accepted request, kept as tag and set like the store splits it
   logic [TAG_BITS-1:0] req_tag_q;
   logic [SET_BITS-1:0] req_set_q;
   logic                re_q;
   vpn_t                req_vpn;

   // Way shown to the client outside the compare cycle
   logic                way_q;

   logic                req_hit;
   logic                accept;
   page_flags_t         merged_flags;

   assign req_vpn = {req_tag_q, req_set_q};
   assign req_hit = |hit_way;

   // Request taken whenever ready is high
   assign accept = dtlb_ready;

   // Walk address stays on the latched request for the whole walk
   assign ptw_vpn  = req_vpn;
   assign fill_vpn = req_vpn;

   // Live request while a new one may come in, latched one during a walk
   assign read_vpn = (state_q == ST_WALKING) ? req_vpn : dtlb_vpn;

   // Hit way goes straight out in the compare cycle
   assign touch_way = hit_way[1];
   assign resp_way  = (state_q == ST_COMPARING) ? hit_way[1] : way_q;

   // Present and writeable need both levels
   // kernel and global need only one
   always_comb begin
      merged_flags = '0;
      merged_flags[FLAG_PRESENT] = ptw_result.pagedir_flags[FLAG_PRESENT] &
                                   ptw_result.pagetab_flags[FLAG_PRESENT];
      merged_flags[FLAG_WRITEABLE] = ptw_result.pagedir_flags[FLAG_WRITEABLE] &
                                     ptw_result.pagetab_flags[FLAG_WRITEABLE];
      merged_flags[FLAG_KERNEL] = ptw_result.pagedir_flags[FLAG_KERNEL] |
                                  ptw_result.pagetab_flags[FLAG_KERNEL];
      merged_flags[FLAG_GLOBAL] = ptw_result.pagedir_flags[FLAG_GLOBAL] |
                                  ptw_result.pagetab_flags[FLAG_GLOBAL];
   end

   assign fill_data.ppn   = ptw_result.ppn;
   assign fill_data.flags = merged_flags;

   // Lookup FSM
   always_comb begin
      next_state = state_q;
      dtlb_ready = 1'b0;
      ptw_re     = 1'b0;
      touch_en   = 1'b0;
      fill_en    = 1'b0;

      case (state_q)
         ST_IDLE: begin
            dtlb_ready = 1'b1;
            if (dtlb_re) begin
               next_state = ST_COMPARING;
            end
         end
         ST_COMPARING: begin
            if (re_q && !req_hit) begin
               // Miss, hold the client off and start one walk
               ptw_re     = 1'b1;
               next_state = ST_WALKING;
            end else begin
               // Hit, answer now and take the next request if any
               dtlb_ready = 1'b1;
               touch_en   = re_q;
               next_state = dtlb_re ? ST_COMPARING : ST_IDLE;
            end
         end
         ST_WALKING: begin
            if (ptw_ready) begin
               // Entry is written at this edge, read back next cycle
               fill_en    = 1'b1;
               next_state = ST_IDLE;
            end
         end
         default: begin
            next_state = ST_IDLE;
         end
      endcase
   end

   // State and control registers
   always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         state_q <= ST_IDLE;
         re_q    <= 1'b0;
         way_q   <= 1'b0;
      end else begin
         state_q <= next_state;
         if (accept) begin
            re_q <= dtlb_re;
         end
         // Filled entry lands in the victim way
         if (fill_en) begin
            way_q <= victim_way;
         end else if (touch_en) begin
            way_q <= hit_way[1];
         end
      end
   end

   // Request payload
   always_ff @(posedge clkrst_mem_clk) begin
      if (accept) begin
         req_tag_q <= dtlb_vpn[19:SET_BITS];
         req_set_q <= dtlb_vpn[SET_BITS-1:0];
      end
   end

endmodule

`default_nettype wire

// ==== dv/ptw_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module ptw_model
   import dtlb_pkg::*;
(
   input  wire logic       clkrst_mem_clk,
   input  wire logic       ptw_re,
   input  wire vpn_t       ptw_vpn,
   input  wire logic [2:0] extra_latency,
   output logic           ptw_ready,
   output walk_result_t   ptw_result,
   output int             walk_count,
   output vpn_t           last_walk_vpn
);

   int   latency;
   int   walks = 0;
   vpn_t walk_vpn = '0;

   assign walk_count    = walks;
   assign last_walk_vpn = walk_vpn;

   // Every cycle with ptw_re high counts, so a long pulse shows up as extra walks
   always @(negedge clkrst_mem_clk) begin
      if (ptw_re) begin
         walks    <= walks + 1;
         walk_vpn <= ptw_vpn;
      end
   end

   // Walk start is seen mid-cycle, answer comes 2 to 9 cycles later
   initial begin
      ptw_ready  = 1'b0;
      ptw_result = '0;
      forever begin
         @(negedge clkrst_mem_clk);
         if (ptw_re) begin
            latency = 2 + int'(extra_latency);
            repeat (latency) @(posedge clkrst_mem_clk);
            #1;
            // Built from ptw_vpn as it is now, a vpn that moved gives a wrong answer
            ptw_result.ppn           = ptw_vpn ^ 20'h5A5A5;
            ptw_result.pagedir_flags = ptw_vpn[3:0];
            ptw_result.pagetab_flags = ptw_vpn[7:4];
            ptw_ready                = 1'b1;
            @(posedge clkrst_mem_clk);
            #1;
            ptw_ready  = 1'b0;
            ptw_result = '0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== dv/tb_dtlb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dtlb
   import dtlb_pkg::*;
();

   localparam int SET_BITS   = 4;
   localparam int NUM_SETS   = 1 << SET_BITS;
   localparam int TIMEOUT    = 64;
   localparam int STREAM_LEN = 40;

   // Single miss target, then three vpns in set 9 with distinct tags
   localparam vpn_t VPN_MISS = 20'h12345;
   localparam vpn_t VPN_A    = 20'hABC39;
   localparam vpn_t VPN_B    = 20'h13579;
   localparam vpn_t VPN_C    = 20'h2F6E9;

   logic         clkrst_mem_clk = 1'b0;
   logic         clkrst_mem_rst_n;
   logic         dtlb_re;
   vpn_t         dtlb_vpn;
   logic         dtlb_ready;
   tlb_resp_t    dtlb_resp;
   logic         ptw_re;
   vpn_t         ptw_vpn;
   logic         ptw_ready;
   walk_result_t ptw_result;
   logic [2:0]   extra_latency;
   int           walk_count;
   vpn_t         last_walk_vpn;

   logic [15:0]  lfsr_q;
   int           error_count;
   int           test_count;
   logic         timed_out;

   // Two-way LRU reference for the stream
   logic [1:0]   ref_valid [NUM_SETS];
   vpn_t         ref_vpn [NUM_SETS][2];
   logic         ref_lru [NUM_SETS];

   dtlb_top #(
      .SET_BITS (SET_BITS)
   ) i_dut (
      .clkrst_mem_clk   (clkrst_mem_clk),
      .clkrst_mem_rst_n (clkrst_mem_rst_n),
      .dtlb_re          (dtlb_re),
      .dtlb_vpn         (dtlb_vpn),
      .dtlb_ready       (dtlb_ready),
      .dtlb_resp        (dtlb_resp),
      .ptw_re           (ptw_re),
      .ptw_vpn          (ptw_vpn),
      .ptw_ready        (ptw_ready),
      .ptw_result       (ptw_result)
   );

   ptw_model i_ptw_model (
      .clkrst_mem_clk (clkrst_mem_clk),
      .ptw_re         (ptw_re),
      .ptw_vpn        (ptw_vpn),
      .extra_latency  (extra_latency),
      .ptw_ready      (ptw_ready),
      .ptw_result     (ptw_result),
      .walk_count     (walk_count),
      .last_walk_vpn  (last_walk_vpn)
   );

   always #50 clkrst_mem_clk = ~clkrst_mem_clk;

   // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [7:0] take_bits(input int n);
      logic [7:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         v = {v[6:0], lfsr_q[0]};
      end
      return v;
   endfunction

   // Walker latency, redrawn during reset and as each walk ends
   always @(posedge clkrst_mem_clk) begin
      if (!clkrst_mem_rst_n || ptw_ready) begin
         extra_latency <= 3'(take_bits(3));
      end
   end

   // ppn is vpn XOR 5A5A5, present and writeable AND the levels, kernel and global OR them
   function automatic tlb_resp_t expected_resp(input vpn_t vpn);
      tlb_resp_t   r;
      page_flags_t pd;
      page_flags_t pt;
      pd    = vpn[3:0];
      pt    = vpn[7:4];
      r.ppn = vpn ^ 20'h5A5A5;
      r.flags[FLAG_PRESENT]   = pd[FLAG_PRESENT] & pt[FLAG_PRESENT];
      r.flags[FLAG_WRITEABLE] = pd[FLAG_WRITEABLE] & pt[FLAG_WRITEABLE];
      r.flags[FLAG_KERNEL]    = pd[FLAG_KERNEL] | pt[FLAG_KERNEL];
      r.flags[FLAG_GLOBAL]    = pd[FLAG_GLOBAL] | pt[FLAG_GLOBAL];
      return r;
   endfunction

   // Stream vpns, idx[2] picks set C or D, the rest gives the tag
   function automatic vpn_t stream_vpn(input logic [2:0] idx);
      return {16'h2B40 + 16'(idx) * 16'h0113, idx[2] ? 4'hD : 4'hC};
   endfunction

   // Returns 1 when the access misses in the reference
   function automatic logic ref_access(input vpn_t vpn);
      int   s;
      logic miss;
      s    = int'(vpn[SET_BITS-1:0]);
      miss = 1'b1;
      for (int w = 0; w < 2; w++) begin
         if (ref_valid[s][w] && ref_vpn[s][w] == vpn) begin
            miss       = 1'b0;
            ref_lru[s] = ~w[0];
         end
      end
      if (miss) begin
         ref_vpn[s][ref_lru[s]]   = vpn;
         ref_valid[s][ref_lru[s]] = 1'b1;
         ref_lru[s]               = ~ref_lru[s];
      end
      return miss;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      error_count++;
   endtask

   task automatic end_test(input string name, input int start_errors);
      test_count++;
      $display("Test %s finished with %0d errors", name, error_count - start_errors);
   endtask

   // Mid-cycle wait for dtlb_ready, cycles counts the negedges taken
   task automatic wait_ready(input string what, output int cycles);
      cycles = 0;
      if (timed_out) begin
         return;
      end
      do begin
         @(negedge clkrst_mem_clk);
         cycles++;
      end while (dtlb_ready !== 1'b1 && cycles < TIMEOUT);
      if (dtlb_ready !== 1'b1) begin
         $display("Timeout at %0t ns: dtlb_ready stayed low while waiting for %s", $time, what);
         timed_out = 1'b1;
      end
   endtask

   task automatic check_resp(input vpn_t vpn, input tlb_resp_t got);
      tlb_resp_t exp;
      exp = expected_resp(vpn);
      if (got.ppn !== exp.ppn) begin
         report_mismatch("dtlb_resp.ppn", 32'(got.ppn), 32'(exp.ppn));
      end
      if (got.flags !== exp.flags) begin
         report_mismatch("dtlb_resp.flags", 32'(got.flags), 32'(exp.flags));
      end
   endtask

   // One request, dtlb_re dropped once it is taken
   task automatic lookup_and_check(input vpn_t vpn, input int exp_walks, output int latency);
      int        start_walks;
      int        accept_cycles;
      tlb_resp_t resp;
      start_walks = walk_count;
      dtlb_re     = 1'b1;
      dtlb_vpn    = vpn;
      wait_ready("request acceptance", accept_cycles);
      @(posedge clkrst_mem_clk);
      #1;
      dtlb_re = 1'b0;
      wait_ready("response", latency);
      resp = dtlb_resp;
      @(posedge clkrst_mem_clk);
      #1;
      if (walk_count - start_walks != exp_walks) begin
         report_mismatch("walk_count", 32'(walk_count - start_walks), 32'(exp_walks));
      end
      check_resp(vpn, resp);
   endtask

   task automatic test_after_reset();
      int start_errors;
      start_errors = error_count;
      @(negedge clkrst_mem_clk);
      if (dtlb_ready !== 1'b1) begin
         report_mismatch("dtlb_ready", 32'(dtlb_ready), 32'd1);
      end
      if (ptw_re !== 1'b0) begin
         report_mismatch("ptw_re", 32'(ptw_re), 32'd0);
      end
      @(posedge clkrst_mem_clk);
      #1;
      end_test("after reset", start_errors);
   endtask

   task automatic test_miss_fill();
      int start_errors;
      int lat;
      start_errors = error_count;
      lookup_and_check(VPN_MISS, 1, lat);
      if (last_walk_vpn !== VPN_MISS) begin
         report_mismatch("ptw_vpn", 32'(last_walk_vpn), 32'(VPN_MISS));
      end
      end_test("miss and fill", start_errors);
   endtask

   task automatic test_repeat_hit();
      int start_errors;
      int lat;
      start_errors = error_count;
      lookup_and_check(VPN_MISS, 0, lat);
      // Hit answers in the cycle right after acceptance
      if (lat != 1) begin
         report_mismatch("dtlb_ready delay", 32'(lat), 32'd1);
      end
      end_test("repeat hit", start_errors);
   endtask

   task automatic test_replacement();
      int start_errors;
      int lat;
      start_errors = error_count;
      lookup_and_check(VPN_A, 1, lat);
      lookup_and_check(VPN_B, 1, lat);
      lookup_and_check(VPN_A, 0, lat);
      // B is least recent now, C takes its way
      lookup_and_check(VPN_C, 1, lat);
      lookup_and_check(VPN_A, 0, lat);
      lookup_and_check(VPN_B, 1, lat);
      end_test("replacement", start_errors);
   endtask

   task automatic test_stream();
      int   start_errors;
      int   start_walks;
      int   ref_walks;
      int   cycles;
      vpn_t cur_vpn;
      vpn_t prev_vpn;
      start_errors = error_count;
      start_walks  = walk_count;
      ref_walks    = 0;
      prev_vpn     = '0;
      for (int s = 0; s < NUM_SETS; s++) begin
         ref_valid[s] = '0;
         ref_lru[s]   = 1'b0;
      end
      for (int i = 0; i < STREAM_LEN; i++) begin
         cur_vpn  = stream_vpn(3'(take_bits(3)));
         dtlb_re  = 1'b1;
         dtlb_vpn = cur_vpn;
         if (ref_access(cur_vpn)) begin
            ref_walks++;
         end
         // Ready cycle answers the previous request and takes this one
         wait_ready("stream handshake", cycles);
         if (i > 0) begin
            check_resp(prev_vpn, dtlb_resp);
         end
         prev_vpn = cur_vpn;
         @(posedge clkrst_mem_clk);
         #1;
      end
      dtlb_re = 1'b0;
      wait_ready("last stream response", cycles);
      check_resp(prev_vpn, dtlb_resp);
      @(posedge clkrst_mem_clk);
      #1;
      if (walk_count - start_walks != ref_walks) begin
         report_mismatch("walk_count", 32'(walk_count - start_walks), 32'(ref_walks));
      end
      end_test("stream", start_errors);
   endtask

   initial begin
      lfsr_q           = 16'd4;
      error_count      = 0;
      test_count       = 0;
      timed_out        = 1'b0;
      dtlb_re          = 1'b0;
      dtlb_vpn         = '0;
      clkrst_mem_rst_n = 1'b0;
      repeat (16) @(posedge clkrst_mem_clk);
      #1;
      clkrst_mem_rst_n = 1'b1;
      test_after_reset();
      test_miss_fill();
      test_repeat_hit();
      test_replacement();
      test_stream();
      $display("Summary: %0d tests, %0d errors, timeout %0d", test_count, error_count, timed_out);
      if (error_count == 0 && !timed_out) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/dtlb_pkg.sv
dtlb/dtlb_entry_store.sv
dtlb/dtlb_lookup_ctrl.sv
verilog/dtlb_top.sv
dv/ptw_model.sv
dv/tb_dtlb.sv

// ==== verilog/dtlb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dtlb_top
   import dtlb_pkg::*;
#(
   parameter int SET_BITS = 4
) (
   input  wire logic         clkrst_mem_clk,
   input  wire logic         clkrst_mem_rst_n,

   // Client side
   input  wire logic         dtlb_re,
   input  wire vpn_t         dtlb_vpn,
   output logic             dtlb_ready,
   output tlb_resp_t        dtlb_resp,

   // Page table walker side
   output logic             ptw_re,
   output vpn_t             ptw_vpn,
   input  wire logic         ptw_ready,
   input  wire walk_result_t ptw_result
);

   // Controller to store
   vpn_t       read_vpn;
   logic [1:0] hit_way;
   logic       touch_en;
   logic       touch_way;
   logic       fill_en;
   vpn_t       fill_vpn;
   tlb_resp_t  fill_data;
   logic       victim_way;
   logic       resp_way;

   dtlb_lookup_ctrl #(
      .SET_BITS (SET_BITS)
   ) i_lookup_ctrl (
      .clkrst_mem_clk   (clkrst_mem_clk),
      .clkrst_mem_rst_n (clkrst_mem_rst_n),
      .dtlb_re          (dtlb_re),
      .dtlb_vpn         (dtlb_vpn),
      .dtlb_ready       (dtlb_ready),
      .ptw_re           (ptw_re),
      .ptw_vpn          (ptw_vpn),
      .ptw_ready        (ptw_ready),
      .ptw_result       (ptw_result),
      .read_vpn         (read_vpn),
      .hit_way          (hit_way),
      .touch_en         (touch_en),
      .touch_way        (touch_way),
      .fill_en          (fill_en),
      .fill_vpn         (fill_vpn),
      .fill_data        (fill_data),
      .victim_way       (victim_way),
      .resp_way         (resp_way)
   );

   // Response comes out of the store
   dtlb_entry_store #(
      .SET_BITS (SET_BITS)
   ) i_entry_store (
      .clkrst_mem_clk   (clkrst_mem_clk),
      .clkrst_mem_rst_n (clkrst_mem_rst_n),
      .read_vpn         (read_vpn),
      .hit_way          (hit_way),
      .touch_en         (touch_en),
      .touch_way        (touch_way),
      .fill_en          (fill_en),
      .fill_vpn         (fill_vpn),
      .fill_data        (fill_data),
      .victim_way       (victim_way),
      .resp_way         (resp_way),
      .resp             (dtlb_resp)
   );

endmodule

`default_nettype wire
